//--- hw/spi_flash_pkg.sv
package spi_flash_pkg;

    // W25Qxx-style single-lane read
    localparam int flash_addr_w = 24;        // 3-byte addressing
    localparam int flash_len_w = 12;         // length minus one
    localparam int flash_addr_bytes = flash_addr_w / 8;

    localparam logic [7:0] flash_read_cmd = 8'h03;   // normal read, no dummy clocks
    localparam logic [7:0] flash_dummy_byte = 8'hAF; // driven on mosi while data returns

endpackage

//--- hw/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic                    amba_clk,
    input  logic                    amba_resetn,
    output logic                    tx_ren,
    input  spi_xfer_pkg::tx_entry_t tx_dout,
    input  logic                    tx_empty,
    output logic                    rx_wen,
    output spi_xfer_pkg::rx_entry_t rx_din,
    input  logic                    rx_full,
    output logic                    sclk,
    output logic                    ss_n,
    output logic                    mosi,
    input  logic                    miso
);

    logic       busy;
    logic       phase;        // 0 sclk low half, 1 high half
    logic [2:0] bit_cnt;
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    logic       cur_capture;
    logic       cur_release;
    logic       cur_last;
    logic       cur_src;
    logic       start;
    logic       byte_done;

    // a capturing byte waits until rx has room
    assign start = ~busy & ~tx_empty & ~(tx_dout.capture & rx_full);
    assign tx_ren = start;
    assign byte_done = busy & phase & (bit_cnt == 3'd7);

    assign mosi = busy & tx_sr[7];
    assign rx_wen = byte_done & cur_capture;

    always_comb
    begin
        rx_din.data = rx_sr;
        rx_din.last = cur_last;
        rx_din.src = cur_src;
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            busy <= 1'b0;
            phase <= 1'b0;
            bit_cnt <= '0;
            sclk <= 1'b0;
            ss_n <= 1'b1;
        end
        else if (start)
        begin
            busy <= 1'b1;
            phase <= 1'b0;
            bit_cnt <= '0;
            ss_n <= 1'b0;    // no-op mid-frame
        end
        else if (busy)
        begin
            phase <= ~phase;
            sclk <= ~phase;  // rises leaving the low half
            if (phase)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7)
                begin
                    busy <= 1'b0;
                    if (cur_release)
                        ss_n <= 1'b1;
                end
            end
        end
    end

    // shift registers and byte flags
    always_ff @(posedge amba_clk)
    begin
        if (start)
        begin
            tx_sr <= tx_dout.data;
            cur_capture <= tx_dout.capture;
            cur_release <= tx_dout.release_ss;
            cur_last <= tx_dout.last;
            cur_src <= tx_dout.src;
        end
        else if (busy)
        begin
            if (!phase)
                rx_sr <= {rx_sr[6:0], miso};   // sampled on the rising edge
            else
                tx_sr <= {tx_sr[6:0], 1'b0};   // next bit while sclk falls
        end
    end

endmodule

//--- hw/spi_sw_cmd_port.sv
`timescale 1ns/1ps

module spi_sw_cmd_port #(
    parameter int sw_fifo_depth = 8
) (
    input  logic                    amba_clk,
    input  logic                    amba_resetn,
    input  logic                    sw_wen,
    input  logic [7:0]              sw_data,
    input  logic                    sw_release_ss,
    output logic                    sw_overflow,
    output spi_xfer_pkg::tx_entry_t req_entry,
    output logic                    req_valid,
    input  logic                    peer_full
);

    import spi_xfer_pkg::*;

    tx_entry_t push_entry;
    logic      q_full;
    logic      q_empty;

    // software frames are write-only, nothing captured
    assign push_entry = '{data: sw_data, release_ss: sw_release_ss, capture: 1'b0,
                          last: 1'b0, src: 1'b1};
    assign req_valid = ~q_empty;

    spi_sync_fifo #(
        .payload_t (tx_entry_t),
        .depth     (sw_fifo_depth)
    ) u_sw_queue (
        .amba_clk    (amba_clk),
        .amba_resetn (amba_resetn),
        .wen         (sw_wen),
        .din         (push_entry),
        .full        (q_full),
        .almost_full (),
        .ren         (req_valid & ~peer_full),
        .dout        (req_entry),
        .empty       (q_empty)
    );

    // sticky until reset
    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
            sw_overflow <= 1'b0;
        else if (sw_wen & q_full)
            sw_overflow <= 1'b1;
    end

endmodule

//--- hw/spi_sync_fifo.sv
`timescale 1ns/1ps

module spi_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth = 16
) (
    input  logic     amba_clk,
    input  logic     amba_resetn,
    input  logic     wen,
    input  payload_t din,
    output logic     full,
    output logic     almost_full,
    input  logic     ren,
    output payload_t dout,
    output logic     empty
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wen & ~full;   // writes into a full buffer are ignored
    assign do_rd = ren & ~empty;

    assign full = (count == cnt_w'(depth));
    assign almost_full = (count >= cnt_w'(depth - 4));
    assign empty = (count == '0);
    assign dout = mem[rd_ptr];    // fall-through head

    always_ff @(posedge amba_clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr & ~do_rd)
                count <= count + 1'b1;
            else if (do_rd & ~do_wr)
                count <= count - 1'b1;
        end
    end

endmodule

//--- hw/spi_tx_arbiter.sv
`timescale 1ns/1ps

module spi_tx_arbiter (
    input  logic                    amba_clk,
    input  logic                    amba_resetn,
    input  spi_xfer_pkg::tx_entry_t xip_entry,
    input  logic                    xip_valid,
    output logic                    xip_full,
    input  spi_xfer_pkg::tx_entry_t sw_entry,
    input  logic                    sw_valid,
    output logic                    sw_full,
    output logic                    tx_wen,
    output spi_xfer_pkg::tx_entry_t tx_din,
    input  logic                    tx_full
);

    logic owner;      // 0 xip, 1 software
    logic locked;     // inside a frame
    logic grant_sw;

    always_comb
    begin
        if (locked)
            grant_sw = owner;
        else if (xip_valid & sw_valid)
            grant_sw = ~owner;   // the one that did not have it last
        else
            grant_sw = sw_valid;
    end

    assign tx_din = grant_sw ? sw_entry : xip_entry;
    assign tx_wen = (grant_sw ? sw_valid : xip_valid) & ~tx_full;

    assign xip_full = tx_full | grant_sw;
    assign sw_full = tx_full | ~grant_sw;

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            owner <= 1'b1;   // first tie goes to xip
            locked <= 1'b0;
        end
        else if (tx_wen)
        begin
            owner <= grant_sw;
            locked <= ~tx_din.release_ss;   // frame closes with its release byte
        end
    end

endmodule

//--- hw/spi_xfer_pkg.sv
package spi_xfer_pkg;

    // one byte slot on the spi bus
    typedef struct packed {
        logic [7:0] data;
        logic       release_ss;   // ss_n goes high after this byte
        logic       capture;      // received byte is kept
        logic       last;         // final captured byte of a read
        logic       src;          // 0 xip, 1 software port
    } tx_entry_t;

    // captured byte on its way to m_axis
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       src;
    } rx_entry_t;

endpackage

//--- hw/spi_xip_ctrler.sv
`timescale 1ns/1ps

module spi_xip_ctrler #(
    parameter int power_on_delay_n = 2000
) (
    input  logic                                    amba_clk,
    input  logic                                    amba_resetn,
    input  logic                                    en_xip,
    input  logic [spi_flash_pkg::flash_addr_w-1:0]  s_axis_addr,
    input  logic [spi_flash_pkg::flash_len_w-1:0]   s_axis_len,
    input  logic                                    s_axis_valid,
    output logic                                    s_axis_ready,
    input  logic                                    rx_almost_full,
    output spi_xfer_pkg::tx_entry_t                 req_entry,
    output logic                                    req_valid,
    input  logic                                    peer_full
);

    import spi_flash_pkg::*;

    localparam int por_cnt_w = $clog2(power_on_delay_n + 2);
    localparam int addr_cnt_w = $clog2(flash_addr_bytes);

    typedef enum logic [1:0] {
        st_idle_cmd,
        st_addr,
        st_data
    } state_t;

    state_t                 state;
    logic [por_cnt_w-1:0]   por_cnt;
    logic                   en_xip_stable;
    logic [flash_addr_w-1:0] addr_sr;
    logic [addr_cnt_w-1:0]  addr_cnt;
    logic [flash_len_w-1:0] len_cnt;
    logic                   last_byte;
    logic                   push;

    assign push = req_valid & ~peer_full;   // entry accepted by the arbiter
    assign s_axis_ready = (state == st_idle_cmd) & en_xip_stable & ~peer_full;

    // flash needs time after power-up before it takes reads
    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
            por_cnt <= '0;
        else if (por_cnt != por_cnt_w'(power_on_delay_n))
            por_cnt <= por_cnt + 1'b1;
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
            en_xip_stable <= 1'b0;
        else
            en_xip_stable <= en_xip & (por_cnt == por_cnt_w'(power_on_delay_n));
    end

    always_comb
    begin
        case (state)
            st_idle_cmd: req_valid = s_axis_valid & en_xip_stable;
            st_addr:     req_valid = 1'b1;
            st_data:     req_valid = ~rx_almost_full;   // hold dummies while rx backs up
            default:     req_valid = 1'b0;
        endcase
    end

    always_comb
    begin
        req_entry.src = 1'b0;
        req_entry.capture = (state == st_data);
        req_entry.last = (state == st_data) & last_byte;
        req_entry.release_ss = (state == st_data) & last_byte;   // frame ends on last dummy
        case (state)
            st_idle_cmd: req_entry.data = flash_read_cmd;
            st_addr:     req_entry.data = addr_sr[flash_addr_w-1 -: 8];   // msb first
            default:     req_entry.data = flash_dummy_byte;
        endcase
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
            state <= st_idle_cmd;
        else if (push)
        begin
            case (state)
                st_idle_cmd:
                    state <= st_addr;
                st_addr:
                    if (addr_cnt == addr_cnt_w'(flash_addr_bytes - 1))
                        state <= st_data;
                st_data:
                    if (last_byte)
                        state <= st_idle_cmd;
                default:
                    state <= st_idle_cmd;
            endcase
        end
    end

    // request fields, loaded on acceptance
    always_ff @(posedge amba_clk)
    begin
        if (s_axis_valid & s_axis_ready)
        begin
            addr_sr <= s_axis_addr;
            addr_cnt <= '0;
            len_cnt <= s_axis_len;
            last_byte <= (s_axis_len == '0);
        end
        else if (push && state == st_addr)
        begin
            addr_sr <= addr_sr << 8;
            addr_cnt <= addr_cnt + 1'b1;
        end
        else if (push && state == st_data)
        begin
            len_cnt <= len_cnt - 1'b1;
            last_byte <= (len_cnt == flash_len_w'(1));
        end
    end

endmodule

//--- hw/spi_xip_top.sv
`timescale 1ns/1ps

module spi_xip_top #(
    parameter int power_on_delay_n = 2000,
    parameter int sw_fifo_depth = 8,
    parameter int tx_fifo_depth = 16,
    parameter int rx_fifo_depth = 16
) (
    input  logic                                    amba_clk,
    input  logic                                    amba_resetn,
    input  logic                                    en_xip,
    input  logic [spi_flash_pkg::flash_addr_w-1:0]  s_axis_addr,
    input  logic [spi_flash_pkg::flash_len_w-1:0]   s_axis_len,
    input  logic                                    s_axis_valid,
    output logic                                    s_axis_ready,
    input  logic                                    sw_wen,
    input  logic [7:0]                              sw_data,
    input  logic                                    sw_release_ss,
    output logic                                    sw_overflow,
    output logic [7:0]                              m_axis_data,
    output logic                                    m_axis_last,
    output logic                                    m_axis_src,
    output logic                                    m_axis_valid,
    input  logic                                    m_axis_ready,
    output logic                                    sclk,
    output logic                                    ss_n,
    output logic                                    mosi,
    input  logic                                    miso
);

    import spi_xfer_pkg::*;

    tx_entry_t xip_entry;
    tx_entry_t sw_entry;
    tx_entry_t tx_din;
    tx_entry_t tx_dout;
    rx_entry_t rx_din;
    rx_entry_t rx_dout;
    logic      xip_valid;
    logic      xip_full;
    logic      sw_valid;
    logic      sw_full;
    logic      tx_wen;
    logic      tx_full;
    logic      tx_ren;
    logic      tx_empty;
    logic      rx_wen;
    logic      rx_full;
    logic      rx_almost_full;
    logic      rx_empty;

    assign m_axis_data = rx_dout.data;
    assign m_axis_last = rx_dout.last;
    assign m_axis_src = rx_dout.src;
    assign m_axis_valid = ~rx_empty;

    spi_xip_ctrler #(
        .power_on_delay_n (power_on_delay_n)
    ) u_xip_ctrler (
        .amba_clk       (amba_clk),
        .amba_resetn    (amba_resetn),
        .en_xip         (en_xip),
        .s_axis_addr    (s_axis_addr),
        .s_axis_len     (s_axis_len),
        .s_axis_valid   (s_axis_valid),
        .s_axis_ready   (s_axis_ready),
        .rx_almost_full (rx_almost_full),
        .req_entry      (xip_entry),
        .req_valid      (xip_valid),
        .peer_full      (xip_full)
    );

    spi_sw_cmd_port #(
        .sw_fifo_depth (sw_fifo_depth)
    ) u_sw_cmd_port (
        .amba_clk      (amba_clk),
        .amba_resetn   (amba_resetn),
        .sw_wen        (sw_wen),
        .sw_data       (sw_data),
        .sw_release_ss (sw_release_ss),
        .sw_overflow   (sw_overflow),
        .req_entry     (sw_entry),
        .req_valid     (sw_valid),
        .peer_full     (sw_full)
    );

    spi_tx_arbiter u_tx_arbiter (
        .amba_clk    (amba_clk),
        .amba_resetn (amba_resetn),
        .xip_entry   (xip_entry),
        .xip_valid   (xip_valid),
        .xip_full    (xip_full),
        .sw_entry    (sw_entry),
        .sw_valid    (sw_valid),
        .sw_full     (sw_full),
        .tx_wen      (tx_wen),
        .tx_din      (tx_din),
        .tx_full     (tx_full)
    );

    spi_sync_fifo #(
        .payload_t (tx_entry_t),
        .depth     (tx_fifo_depth)
    ) u_tx_fifo (
        .amba_clk    (amba_clk),
        .amba_resetn (amba_resetn),
        .wen         (tx_wen),
        .din         (tx_din),
        .full        (tx_full),
        .almost_full (),
        .ren         (tx_ren),
        .dout        (tx_dout),
        .empty       (tx_empty)
    );

    spi_shift_engine u_shift_engine (
        .amba_clk    (amba_clk),
        .amba_resetn (amba_resetn),
        .tx_ren      (tx_ren),
        .tx_dout     (tx_dout),
        .tx_empty    (tx_empty),
        .rx_wen      (rx_wen),
        .rx_din      (rx_din),
        .rx_full     (rx_full),
        .sclk        (sclk),
        .ss_n        (ss_n),
        .mosi        (mosi),
        .miso        (miso)
    );

    // read side of rx drains straight into m_axis
    spi_sync_fifo #(
        .payload_t (rx_entry_t),
        .depth     (rx_fifo_depth)
    ) u_rx_fifo (
        .amba_clk    (amba_clk),
        .amba_resetn (amba_resetn),
        .wen         (rx_wen),
        .din         (rx_din),
        .full        (rx_full),
        .almost_full (rx_almost_full),
        .ren         (m_axis_ready),
        .dout        (rx_dout),
        .empty       (rx_empty)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the XIP testbench with Verilator
verilator --binary --timing --assert --top-module tb_spi_xip -f spi_xip.f -o sim_spi_xip \
    && ./obj_dir/sim_spi_xip | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- spi_xip.f
hw/spi_flash_pkg.sv
hw/spi_xfer_pkg.sv
hw/spi_sync_fifo.sv
hw/spi_xip_ctrler.sv
hw/spi_sw_cmd_port.sv
hw/spi_tx_arbiter.sv
hw/spi_shift_engine.sv
hw/spi_xip_top.sv
tests/spi_xip_checker.sv
tests/spi_xip_assert.sv
tests/tb_spi_xip.sv

//--- tests/spi_xip_assert.sv
`timescale 1ns/1ps

module spi_xip_assert (
    input logic       amba_clk,
    input logic       amba_resetn,
    input logic       m_axis_valid,
    input logic       m_axis_ready,
    input logic [7:0] m_axis_data,
    input logic       m_axis_last,
    input logic       m_axis_src,
    input logic       rx_wen,
    input logic       rx_full,
    input logic       ss_n,
    input logic       sclk
);

    a_axis_hold: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis_data)
            && $stable(m_axis_last) && $stable(m_axis_src))
        else $error("m_axis payload changed before ready");

    // a capturing byte only starts when rx has room for it
    a_no_rx_overrun: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        !(rx_wen && rx_full))
        else $error("rx_wen high while rx_full");

    // sclk idles low outside a frame
    a_sclk_idle: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        ss_n |-> !sclk)
        else $error("sclk active while ss_n high");

endmodule

bind spi_xip_top spi_xip_assert u_assert (
    .amba_clk     (amba_clk),
    .amba_resetn  (amba_resetn),
    .m_axis_valid (m_axis_valid),
    .m_axis_ready (m_axis_ready),
    .m_axis_data  (m_axis_data),
    .m_axis_last  (m_axis_last),
    .m_axis_src   (m_axis_src),
    .rx_wen       (rx_wen),
    .rx_full      (rx_full),
    .ss_n         (ss_n),
    .sclk         (sclk)
);

//--- tests/spi_xip_checker.sv
`timescale 1ns/1ps

module spi_xip_checker #(
    parameter int power_on_delay_n = 40
) (
    input logic       amba_clk,
    input logic       amba_resetn,
    input logic       s_axis_ready,
    input logic       sw_overflow,
    input logic [7:0] m_axis_data,
    input logic       m_axis_last,
    input logic       m_axis_src,
    input logic       m_axis_valid,
    input logic       m_axis_ready,
    input logic       sclk,
    input logic       ss_n,
    input logic       mosi
);

    import spi_flash_pkg::*;

    int         error_count = 0;
    int         frame_count = 0;
    int         read_count = 0;
    int         por_cycles = 0;
    int         bit_cnt = 0;
    logic [7:0] shift_in = '0;
    logic       exp_overflow = 1'b0;
    logic [7:0] win_q [$];        // mosi bytes of the open ss_n window
    logic [7:0] xip_byte_q [$];
    int         xip_len_q [$];
    logic [7:0] sw_byte_q [$];
    int         sw_len_q [$];
    logic [7:0] data_q [$];
    logic       last_q [$];

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (exp !== got)
        begin
            $display("** Error at %0t ns: %s expected 0x%02h got 0x%02h", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic report(input string text);
        $display("checker at %0t ns: %s", $time, text);
        error_count++;
    endtask

    task automatic expect_read(input logic [23:0] addr, input logic [11:0] len);
        logic [23:0] a;
        xip_byte_q.push_back(8'h03);
        xip_byte_q.push_back(addr[23:16]);   // address goes out high byte first
        xip_byte_q.push_back(addr[15:8]);
        xip_byte_q.push_back(addr[7:0]);
        for (int i = 0; i <= int'(len); i++)
        begin
            a = addr + 24'(i);
            xip_byte_q.push_back(8'hAF);
            data_q.push_back(a[7:0] ^ 8'h5A);   // flash model content
            last_q.push_back(i == int'(len));
        end
        xip_len_q.push_back(int'(len) + 5);
    endtask

    task automatic expect_sw_byte(input logic [7:0] b);
        sw_byte_q.push_back(b);
    endtask

    task automatic expect_sw_frame(input int n);
        sw_len_q.push_back(n);
    endtask

    task automatic expect_overflow();
        exp_overflow = 1'b1;
    endtask

    function automatic logic all_done();
        return (xip_len_q.size() == 0) && (sw_len_q.size() == 0) && (data_q.size() == 0);
    endfunction

    task automatic close_window();
        int         n;
        logic       is_xip;
        logic [7:0] exp_b;
        is_xip = (win_q[0] == flash_read_cmd);
        if (is_xip && xip_len_q.size() == 0)
            report("read frame on the bus that was never requested");
        else if (!is_xip && sw_len_q.size() == 0)
            report("software frame on the bus that was never issued");
        else
        begin
            if (is_xip)
                n = xip_len_q.pop_front();
            else
                n = sw_len_q.pop_front();
            if (win_q.size() != n)
                report($sformatf("ss_n window holds %0d bytes, frame has %0d", win_q.size(), n));
            for (int i = 0; i < n; i++)
            begin
                if (is_xip)
                    exp_b = xip_byte_q.pop_front();
                else
                    exp_b = sw_byte_q.pop_front();
                if (i < win_q.size())
                    check_value("mosi", exp_b, win_q[i]);
            end
        end
        frame_count++;
    endtask

    // flash side samples mosi on the rising sclk
    always @(posedge sclk)
    begin
        if (!ss_n)
        begin
            shift_in = {shift_in[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                win_q.push_back(shift_in);
                bit_cnt = 0;
            end
        end
    end

    always @(posedge ss_n)
    begin
        if (bit_cnt != 0)
            report("ss_n rose in the middle of a byte");
        bit_cnt = 0;
        if (win_q.size() > 0)
            close_window();
        win_q.delete();
    end

    always @(posedge amba_clk)
    begin
        if (!amba_resetn)
        begin
            por_cycles = 0;
            if (ss_n !== 1'b1 || sclk !== 1'b0)
                report("ss_n or sclk not idle during reset");
            if (m_axis_valid !== 1'b0 || sw_overflow !== 1'b0)
                report("m_axis_valid or sw_overflow set during reset");
        end
        else
        begin
            if (por_cycles <= power_on_delay_n && s_axis_ready)
                report($sformatf("s_axis_ready high %0d cycles after reset", por_cycles));
            if (por_cycles <= power_on_delay_n)
                por_cycles++;
            if (m_axis_valid && m_axis_ready)
            begin
                read_count++;
                if (m_axis_src !== 1'b0)
                    check_value("m_axis_src", 8'h00, {7'h0, m_axis_src});
                if (data_q.size() == 0)
                    report("m_axis byte with no read outstanding");
                else
                begin
                    check_value("m_axis_data", data_q.pop_front(), m_axis_data);
                    check_value("m_axis_last", {7'h0, last_q.pop_front()}, {7'h0, m_axis_last});
                end
            end
        end
    end

    task automatic final_report();
        check_value("sw_overflow", {7'h0, exp_overflow}, {7'h0, sw_overflow});
        if (!all_done())
            report("requests still outstanding at the end of the run");
        $display("checker: %0d frames, %0d read bytes, %0d errors",
                 frame_count, read_count, error_count);
    endtask

endmodule

//--- tests/tb_spi_xip.sv
`timescale 1ns/1ps

module tb_spi_xip;

    localparam int por_delay = 40;
    localparam int sw_depth = 8;
    localparam int n_rows = 6;

    // request, software bytes (first byte high), issued alongside, ready stall cycles
    logic [23:0] t_addr [n_rows] = '{24'h000100, 24'h1234F8, 24'hABCDE0,
                                     24'h000010, 24'h7FFFFE, 24'h00FF00};
    logic [11:0] t_len [n_rows] = '{12'd3, 12'd15, 12'd40, 12'd7, 12'd20, 12'd0};
    int          t_nsw [n_rows] = '{0, 0, 0, 3, 10, 2};
    logic [79:0] t_sw [n_rows] = '{80'h0, 80'h0, 80'h0,
                                   80'h059F06_00000000000000,
                                   80'h06C7_20_21_22_23_24_25_26_27,
                                   80'h06C7_0000000000000000};
    logic        t_along [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    int          t_stall [n_rows] = '{0, 0, 600, 0, 0, 0};

    logic        amba_clk = 1'b0;
    logic        amba_resetn;
    logic        en_xip;
    logic [23:0] s_axis_addr;
    logic [11:0] s_axis_len;
    logic        s_axis_valid;
    logic        s_axis_ready;
    logic        sw_wen;
    logic [7:0]  sw_data;
    logic        sw_release_ss;
    logic        sw_overflow;
    logic [7:0]  m_axis_data;
    logic        m_axis_last;
    logic        m_axis_src;
    logic        m_axis_valid;
    logic        m_axis_ready;
    logic        sclk;
    logic        ss_n;
    logic        mosi;
    logic        miso;
    logic        stall = 1'b0;
    logic [15:0] lfsr_state = 16'd13284;
    int          cycle_cnt = 0;
    int          limit;
    logic [7:0]  flash_in = '0;
    logic [7:0]  flash_out = 8'hFF;
    logic [7:0]  flash_cmd = '0;
    logic [23:0] flash_addr = '0;
    int          flash_bits = 0;
    int          flash_bytes = 0;

    always #5 amba_clk = ~amba_clk;

    spi_xip_top #(
        .power_on_delay_n (por_delay),
        .sw_fifo_depth    (sw_depth),
        .tx_fifo_depth    (16),
        .rx_fifo_depth    (16)
    ) UUT (.*);

    spi_xip_checker #(
        .power_on_delay_n (por_delay)
    ) u_check (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [7:0] sw_byte(input int r, input int k);
        return t_sw[r][79 - 8*k -: 8];
    endfunction

    function automatic int timeout_limit();
        int sum;
        sum = 0;
        for (int r = 0; r < n_rows; r++)
            sum += 17 * (int'(t_len[r]) + 1 + t_nsw[r] + 4) + t_stall[r];
        return (sum + por_delay) * 2;
    endfunction

    // flash model in spi mode 0 that only answers reads
    assign miso = flash_out[7];

    always @(negedge ss_n)
    begin
        flash_bits = 0;
        flash_bytes = 0;
        flash_out = 8'hFF;
    end

    always @(posedge sclk)
    begin
        flash_in = {flash_in[6:0], mosi};
        flash_bits++;
        if (flash_bits == 8)
        begin
            flash_bits = 0;
            if (flash_bytes == 0)
                flash_cmd = flash_in;
            else if (flash_bytes < 4)
                flash_addr = {flash_addr[15:0], flash_in};
            flash_bytes++;
        end
    end

    always @(negedge sclk)
    begin
        logic [23:0] a;
        if (flash_bits != 0)
            flash_out = {flash_out[6:0], 1'b1};
        else if (flash_cmd == 8'h03 && flash_bytes >= 4)
        begin
            a = flash_addr + 24'(flash_bytes - 4);
            flash_out = a[7:0] ^ 8'h5A;
        end
        else
            flash_out = 8'hFF;   // nothing to say in a software frame
    end

    always @(posedge amba_clk)
    begin
        #1;
        lfsr_state = lfsr_step(lfsr_state);
        m_axis_ready = lfsr_state[0] & ~stall;
    end

    always @(posedge amba_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > limit)
        begin
            $display("timeout: run passed %0d cycles without finishing", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic apply_row(input int r);
        int n_keep;
        n_keep = (t_nsw[r] > sw_depth) ? sw_depth : t_nsw[r];   // the rest is dropped
        u_check.expect_read(t_addr[r], t_len[r]);
        for (int k = 0; k < n_keep; k++)
            u_check.expect_sw_byte(sw_byte(r, k));
        if (n_keep > 0)
            u_check.expect_sw_frame(n_keep);
        if (t_nsw[r] > sw_depth)
            u_check.expect_overflow();
        s_axis_addr = t_addr[r];
        s_axis_len = t_len[r];
        s_axis_valid = 1'b1;
        @(posedge amba_clk);
        while (!s_axis_ready)
            @(posedge amba_clk);
        #1 s_axis_valid = 1'b0;
        if (t_stall[r] > 0)
        begin
            stall = 1'b1;
            repeat (t_stall[r]) @(posedge amba_clk);
            #1 stall = 1'b0;
        end
        if (t_along[r])
        begin
            if (t_nsw[r] > sw_depth)
            begin
                while (ss_n)   // read frame owns the bus
                begin
                    @(posedge amba_clk);
                    #1;
                end
            end
            for (int k = 0; k < t_nsw[r]; k++)
            begin
                sw_wen = 1'b1;
                sw_data = sw_byte(r, k);
                sw_release_ss = (k == n_keep - 1) || (k == t_nsw[r] - 1);
                @(posedge amba_clk);
                #1;
            end
            sw_wen = 1'b0;
        end
        while (!u_check.all_done())
            @(posedge amba_clk);
        #1;
    endtask

    initial
    begin
        amba_resetn = 1'b1;
        en_xip = 1'b1;
        s_axis_addr = '0;
        s_axis_len = '0;
        s_axis_valid = 1'b0;
        sw_wen = 1'b0;
        sw_data = '0;
        sw_release_ss = 1'b0;
        m_axis_ready = 1'b0;
        limit = timeout_limit();
        #1 amba_resetn = 1'b0;
        repeat (5) @(posedge amba_clk);
        #1 amba_resetn = 1'b1;
        for (int r = 0; r < n_rows; r++)
            apply_row(r);
        u_check.final_report();
        if (u_check.error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
